/* rtl/taint_mult_pkg.sv */
// ======================================================================
// Multiplier widths, bit index width and controller state encoding
// ======================================================================

package taint_mult_pkg;

	// ==================================================================
	// Widths
	// ==================================================================

	localparam int OPERAND_WIDTH = 8;

	// Product holds the full unsigned result
	localparam int PRODUCT_WIDTH = 2 * OPERAND_WIDTH;

	// Index into the multiplier bits
	localparam int INDEX_WIDTH = $clog2(OPERAND_WIDTH);

	// ==================================================================
	// Controller states
	// ==================================================================

	typedef enum logic [2:0] {
		IDLE  = 3'd0,
		INIT  = 3'd1,
		ADD   = 3'd2,
		SHIFT = 3'd3,
		DONE  = 3'd4
	} ctrl_state_t;

endpackage

/* rtl/apb_map_pkg.sv */
// ======================================================================
// APB bus widths, register offsets and control/status bit positions
// ======================================================================

package apb_map_pkg;

	localparam int APB_ADDR_WIDTH = 8;
	localparam int APB_DATA_WIDTH = 32;

	// Register offsets
	localparam logic [APB_ADDR_WIDTH-1:0] REG_CTRL      = 8'h00;
	localparam logic [APB_ADDR_WIDTH-1:0] REG_STATUS    = 8'h04;
	localparam logic [APB_ADDR_WIDTH-1:0] REG_MCAND     = 8'h08;
	localparam logic [APB_ADDR_WIDTH-1:0] REG_MCAND_T   = 8'h0C;
	localparam logic [APB_ADDR_WIDTH-1:0] REG_MPLIER    = 8'h10;
	localparam logic [APB_ADDR_WIDTH-1:0] REG_MPLIER_T  = 8'h14;
	localparam logic [APB_ADDR_WIDTH-1:0] REG_PRODUCT   = 8'h18;
	localparam logic [APB_ADDR_WIDTH-1:0] REG_PRODUCT_T = 8'h1C;

	// Bit positions in CTRL and STATUS
	localparam int CTRL_START_BIT    = 0;
	localparam int CTRL_START_T_BIT  = 1;
	localparam int STATUS_BUSY_BIT   = 0;
	localparam int STATUS_DONE_BIT   = 1;
	localparam int STATUS_DONE_T_BIT = 2;

endpackage

/* rtl/bit_counter.sv */
// ======================================================================
// Multiplier bit position counter with last-bit flag
// ======================================================================

`timescale 1ns/1ps

module bit_counter import taint_mult_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   cnt_clear,
	input  logic                   cnt_step,
	output logic [INDEX_WIDTH-1:0] bit_index,
	output logic                   last_bit
);

	localparam logic [INDEX_WIDTH-1:0] LAST_INDEX = INDEX_WIDTH'(OPERAND_WIDTH - 1);

	logic [INDEX_WIDTH-1:0] count;

	// Wraps back to zero after the final shift
	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else if (cnt_clear) begin
			count <= '0;
		end else if (cnt_step) begin
			count <= count + INDEX_WIDTH'(1);
		end
	end

	assign bit_index = count;
	assign last_bit  = (count == LAST_INDEX);

endmodule

/* rtl/mult_ctrl.sv */
// ======================================================================
// Shift-and-add controller FSM with a single state-taint bit
// ======================================================================

`timescale 1ns/1ps

module mult_ctrl import taint_mult_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic start_t,
	input  logic mr_bit,
	input  logic mr_bit_t,
	input  logic last_bit,
	output logic rs_clear,
	output logic rs_clear_t,
	output logic md_load,
	output logic md_load_t,
	output logic mr_load,
	output logic mr_load_t,
	output logic rs_add,
	output logic rs_add_t,
	output logic rs_shift,
	output logic rs_shift_t,
	output logic cnt_clear,
	output logic cnt_step,
	output logic product_done,
	output logic product_done_t
);

	ctrl_state_t state;
	ctrl_state_t state_next;
	logic        state_t;
	logic        state_t_next;

	// Strobes decoded from the state alone
	always_comb begin
		rs_clear     = 1'b0;
		md_load      = 1'b0;
		mr_load      = 1'b0;
		rs_add       = 1'b0;
		rs_shift     = 1'b0;
		cnt_clear    = 1'b0;
		cnt_step     = 1'b0;
		product_done = 1'b0;
		case (state)
			INIT: begin
				rs_clear  = 1'b1;
				md_load   = 1'b1;
				mr_load   = 1'b1;
				cnt_clear = 1'b1;
			end
			ADD:   rs_add = 1'b1;
			SHIFT: begin
				rs_shift = 1'b1;
				cnt_step = 1'b1;
			end
			DONE:  product_done = 1'b1;
			default: ;
		endcase
	end

	// A tainted state taints whatever strobe it drives
	assign rs_clear_t     = rs_clear & state_t;
	assign md_load_t      = md_load & state_t;
	assign mr_load_t      = mr_load & state_t;
	assign rs_add_t       = rs_add & state_t;
	assign rs_shift_t     = rs_shift & state_t;
	assign product_done_t = product_done & state_t;

	// Next state and taint
	always_comb begin
		state_next   = state;
		state_t_next = state_t;
		case (state)
			IDLE: begin
				state_t_next = 1'b0;
				if (start) begin
					state_next   = INIT;
					state_t_next = start_t;
				end
			end
			INIT: begin
				// Branch on bit 0 as it loads
				state_next   = mr_bit ? ADD : SHIFT;
				state_t_next = state_t | mr_bit_t;
			end
			ADD: state_next = SHIFT;
			SHIFT: begin
				if (last_bit) begin
					state_next = DONE;
				end else begin
					state_next   = mr_bit ? ADD : SHIFT;
					state_t_next = state_t | mr_bit_t;
				end
			end
			DONE: begin
				state_next   = IDLE;
				state_t_next = 1'b0;
			end
			default: begin
				state_next   = IDLE;
				state_t_next = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= IDLE;
			state_t <= 1'b0;
		end else begin
			state   <= state_next;
			state_t <= state_t_next;
		end
	end

endmodule

/* rtl/mult_datapath.sv */
// ======================================================================
// Operand and result registers with taint shadows
// Tainted adder and right shift of the partial product
// ======================================================================

`timescale 1ns/1ps

module mult_datapath import taint_mult_pkg::*; (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     rs_clear,
	input  logic                     rs_clear_t,
	input  logic                     md_load,
	input  logic                     md_load_t,
	input  logic                     mr_load,
	input  logic                     mr_load_t,
	input  logic                     rs_add,
	input  logic                     rs_add_t,
	input  logic                     rs_shift,
	input  logic                     rs_shift_t,
	input  logic [INDEX_WIDTH-1:0]   bit_index,
	input  logic [OPERAND_WIDTH-1:0] mcand,
	input  logic [OPERAND_WIDTH-1:0] mcand_t,
	input  logic [OPERAND_WIDTH-1:0] mplier,
	input  logic [OPERAND_WIDTH-1:0] mplier_t,
	output logic                     mr_bit,
	output logic                     mr_bit_t,
	output logic [PRODUCT_WIDTH-1:0] product,
	output logic [PRODUCT_WIDTH-1:0] product_t
);

	logic [OPERAND_WIDTH-1:0] md;
	logic [OPERAND_WIDTH-1:0] md_t;
	logic [OPERAND_WIDTH-1:0] mr;
	logic [OPERAND_WIDTH-1:0] mr_t;
	// One extra bit on top catches the adder carry
	logic [PRODUCT_WIDTH:0]   rs;
	logic [PRODUCT_WIDTH:0]   rs_t;
	logic [OPERAND_WIDTH:0]   add_sum;
	logic [OPERAND_WIDTH:0]   add_sum_t;
	logic [INDEX_WIDTH-1:0]   next_index;

	// Every sum bit from the lowest tainted addend bit upward
	function automatic logic [OPERAND_WIDTH:0] carry_taint(
		input logic [OPERAND_WIDTH-1:0] t
	);
		logic [OPERAND_WIDTH:0] spread;
		logic                   seen;
		seen = 1'b0;
		for (int i = 0; i < OPERAND_WIDTH; i++) begin
			seen      = seen | t[i];
			spread[i] = seen;
		end
		spread[OPERAND_WIDTH] = seen;
		return spread;
	endfunction

	assign add_sum   = {1'b0, rs[PRODUCT_WIDTH-1:OPERAND_WIDTH]} + {1'b0, md};
	assign add_sum_t = carry_taint(rs_t[PRODUCT_WIDTH-1:OPERAND_WIDTH] | md_t);

	// Controller decides one bit ahead, bit 0 comes straight from the load
	assign next_index = bit_index + INDEX_WIDTH'(1);

	always_comb begin
		if (mr_load) begin
			mr_bit   = mplier[0];
			mr_bit_t = mplier_t[0] | mr_load_t;
		end else begin
			mr_bit   = mr[next_index];
			mr_bit_t = mr_t[next_index];
		end
	end

	always_ff @(posedge clk) begin
		if (md_load) md <= mcand;
		if (mr_load) mr <= mplier;
		if (rs_clear) begin
			rs <= '0;
		end else if (rs_add) begin
			rs[PRODUCT_WIDTH:OPERAND_WIDTH] <= add_sum;
		end else if (rs_shift) begin
			rs <= {1'b0, rs[PRODUCT_WIDTH:1]};
		end
	end

	// ==================================================================
	// Taint shadows
	// ==================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			md_t <= '0;
			mr_t <= '0;
			rs_t <= '0;
		end else begin
			if (md_load) md_t <= md_load_t ? '1 : mcand_t;
			if (mr_load) mr_t <= mr_load_t ? '1 : mplier_t;
			if (rs_clear) begin
				rs_t <= rs_clear_t ? '1 : '0;
			end else if (rs_add) begin
				if (rs_add_t) rs_t <= '1;
				else rs_t[PRODUCT_WIDTH:OPERAND_WIDTH] <= add_sum_t;
			end else if (rs_shift) begin
				rs_t <= rs_shift_t ? '1 : {1'b0, rs_t[PRODUCT_WIDTH:1]};
			end
		end
	end

	assign product   = rs[PRODUCT_WIDTH-1:0];
	assign product_t = rs_t[PRODUCT_WIDTH-1:0];

endmodule

/* rtl/apb_mult_regs.sv */
// ======================================================================
// APB slave register file for operands, taint masks and start
// Busy/done status and product readback
// ======================================================================

`timescale 1ns/1ps

module apb_mult_regs import taint_mult_pkg::*, apb_map_pkg::*; (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [APB_ADDR_WIDTH-1:0] paddr,
	input  logic [APB_DATA_WIDTH-1:0] pwdata,
	output logic [APB_DATA_WIDTH-1:0] prdata,
	output logic                      pready,
	output logic                      pslverr,
	input  logic                      product_done,
	input  logic                      product_done_t,
	input  logic [PRODUCT_WIDTH-1:0]  product,
	input  logic [PRODUCT_WIDTH-1:0]  product_t,
	output logic                      start,
	output logic                      start_t,
	output logic [OPERAND_WIDTH-1:0]  mcand,
	output logic [OPERAND_WIDTH-1:0]  mcand_t,
	output logic [OPERAND_WIDTH-1:0]  mplier,
	output logic [OPERAND_WIDTH-1:0]  mplier_t
);

	logic access;
	logic mapped;
	logic read_only;
	logic operand_reg;
	logic write_ok;
	logic busy;
	logic done;
	logic done_t;

	assign access = psel & penable;

	// ==================================================================
	// Address decode
	// ==================================================================

	always_comb begin
		mapped      = 1'b1;
		read_only   = 1'b0;
		operand_reg = 1'b0;
		case (paddr)
			REG_CTRL:                                  mapped = 1'b1;
			REG_STATUS, REG_PRODUCT, REG_PRODUCT_T:    read_only = 1'b1;
			REG_MCAND, REG_MCAND_T, REG_MPLIER, REG_MPLIER_T: operand_reg = 1'b1;
			default:                                   mapped = 1'b0;
		endcase
	end

	// Operands stay frozen while a multiply runs
	assign pslverr  = access & (~mapped | (pwrite & read_only) | (pwrite & operand_reg & busy));
	assign write_ok = access & pwrite & ~pslverr;
	assign pready   = 1'b1;

	// One-cycle start pulse, dropped silently when busy
	assign start   = write_ok & (paddr == REG_CTRL) & pwdata[CTRL_START_BIT] & ~busy;
	assign start_t = start & pwdata[CTRL_START_T_BIT];

	always_ff @(posedge clk) begin
		if (write_ok) begin
			if (paddr == REG_MCAND)  mcand  <= pwdata[OPERAND_WIDTH-1:0];
			if (paddr == REG_MPLIER) mplier <= pwdata[OPERAND_WIDTH-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mcand_t  <= '0;
			mplier_t <= '0;
		end else if (write_ok) begin
			if (paddr == REG_MCAND_T)  mcand_t  <= pwdata[OPERAND_WIDTH-1:0];
			if (paddr == REG_MPLIER_T) mplier_t <= pwdata[OPERAND_WIDTH-1:0];
		end
	end

	// ==================================================================
	// Status
	// ==================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			busy   <= 1'b0;
			done   <= 1'b0;
			done_t <= 1'b0;
		end else if (start) begin
			busy   <= 1'b1;
			done   <= 1'b0;
			done_t <= 1'b0;
		end else if (product_done) begin
			busy   <= 1'b0;
			done   <= 1'b1;
			done_t <= product_done_t;
		end
	end

	// Read mux, CTRL reads back as zero
	always_comb begin
		prdata = '0;
		if (access && !pwrite) begin
			case (paddr)
				REG_STATUS: begin
					prdata[STATUS_BUSY_BIT]   = busy;
					prdata[STATUS_DONE_BIT]   = done;
					prdata[STATUS_DONE_T_BIT] = done_t;
				end
				REG_MCAND:     prdata = APB_DATA_WIDTH'(mcand);
				REG_MCAND_T:   prdata = APB_DATA_WIDTH'(mcand_t);
				REG_MPLIER:    prdata = APB_DATA_WIDTH'(mplier);
				REG_MPLIER_T:  prdata = APB_DATA_WIDTH'(mplier_t);
				REG_PRODUCT:   prdata = APB_DATA_WIDTH'(product);
				REG_PRODUCT_T: prdata = APB_DATA_WIDTH'(product_t);
				default:       prdata = '0;
			endcase
		end
	end

endmodule

/* rtl/taint_mult_top.sv */
// ======================================================================
// Top level of the taint-tracking multiplier behind an APB slave
// ======================================================================

`timescale 1ns/1ps

module taint_mult_top import taint_mult_pkg::*, apb_map_pkg::*; (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [APB_ADDR_WIDTH-1:0] paddr,
	input  logic [APB_DATA_WIDTH-1:0] pwdata,
	output logic [APB_DATA_WIDTH-1:0] prdata,
	output logic                      pready,
	output logic                      pslverr
);

	// Register file handshake
	logic                     start;
	logic                     start_t;
	logic                     product_done;
	logic                     product_done_t;
	logic [OPERAND_WIDTH-1:0] mcand;
	logic [OPERAND_WIDTH-1:0] mcand_t;
	logic [OPERAND_WIDTH-1:0] mplier;
	logic [OPERAND_WIDTH-1:0] mplier_t;
	logic [PRODUCT_WIDTH-1:0] product;
	logic [PRODUCT_WIDTH-1:0] product_t;

	// Controller strobes and their taints
	logic rs_clear;
	logic rs_clear_t;
	logic md_load;
	logic md_load_t;
	logic mr_load;
	logic mr_load_t;
	logic rs_add;
	logic rs_add_t;
	logic rs_shift;
	logic rs_shift_t;
	logic cnt_clear;
	logic cnt_step;

	// Bit selection
	logic [INDEX_WIDTH-1:0] bit_index;
	logic                   last_bit;
	logic                   mr_bit;
	logic                   mr_bit_t;

	apb_mult_regs u_regs (
		.clk(clk), .rst(rst),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.product_done(product_done), .product_done_t(product_done_t),
		.product(product), .product_t(product_t),
		.start(start), .start_t(start_t),
		.mcand(mcand), .mcand_t(mcand_t),
		.mplier(mplier), .mplier_t(mplier_t)
	);

	mult_ctrl u_ctrl (
		.clk(clk), .rst(rst),
		.start(start), .start_t(start_t),
		.mr_bit(mr_bit), .mr_bit_t(mr_bit_t), .last_bit(last_bit),
		.rs_clear(rs_clear), .rs_clear_t(rs_clear_t),
		.md_load(md_load), .md_load_t(md_load_t),
		.mr_load(mr_load), .mr_load_t(mr_load_t),
		.rs_add(rs_add), .rs_add_t(rs_add_t),
		.rs_shift(rs_shift), .rs_shift_t(rs_shift_t),
		.cnt_clear(cnt_clear), .cnt_step(cnt_step),
		.product_done(product_done), .product_done_t(product_done_t)
	);

	bit_counter u_counter (
		.clk(clk), .rst(rst),
		.cnt_clear(cnt_clear), .cnt_step(cnt_step),
		.bit_index(bit_index), .last_bit(last_bit)
	);

	mult_datapath u_datapath (
		.clk(clk), .rst(rst),
		.rs_clear(rs_clear), .rs_clear_t(rs_clear_t),
		.md_load(md_load), .md_load_t(md_load_t),
		.mr_load(mr_load), .mr_load_t(mr_load_t),
		.rs_add(rs_add), .rs_add_t(rs_add_t),
		.rs_shift(rs_shift), .rs_shift_t(rs_shift_t),
		.bit_index(bit_index),
		.mcand(mcand), .mcand_t(mcand_t),
		.mplier(mplier), .mplier_t(mplier_t),
		.mr_bit(mr_bit), .mr_bit_t(mr_bit_t),
		.product(product), .product_t(product_t)
	);

endmodule

/* dv/taint_mult_assert.sv */
// ======================================================================
// Concurrent assertions on the multiplier top level, bound to it
// Latency, strobe exclusivity, reset quiet and APB ready checks
// ======================================================================

`timescale 1ns/1ps

module taint_mult_assert import taint_mult_pkg::*; (
	input logic                     clk,
	input logic                     rst,
	input logic                     start,
	input logic                     product_done,
	input logic                     rs_clear,
	input logic                     md_load,
	input logic                     mr_load,
	input logic                     rs_add,
	input logic                     rs_shift,
	input logic                     cnt_clear,
	input logic                     cnt_step,
	input logic [OPERAND_WIDTH-1:0] mplier,
	input logic                     pready
);

	int fail_count = 0;

	logic       running;
	logic [5:0] elapsed;
	logic [5:0] expected;

	// Cycle count since the start pulse, and the latency the multiplier bits call for
	always_ff @(posedge clk) begin
		if (rst) begin
			running  <= 1'b0;
			elapsed  <= '0;
			expected <= '0;
		end else if (start) begin
			running  <= 1'b1;
			elapsed  <= 6'd1;
			expected <= 6'd10 + 6'($countones(mplier));
		end else if (running) begin
			elapsed <= elapsed + 6'd1;
			if (product_done) running <= 1'b0;
		end
	end

	// ==================================================================
	// Timing
	// ==================================================================

	a_latency: assert property (@(posedge clk) disable iff (rst)
		product_done |-> (running && elapsed == expected))
	else begin
		fail_count++;
		$error("product_done after %0d cycles, expected %0d", elapsed, expected);
	end

	a_not_late: assert property (@(posedge clk) disable iff (rst)
		running |-> (elapsed < expected || product_done))
	else begin
		fail_count++;
		$error("product_done missing after %0d cycles", elapsed);
	end

	a_done_pulse: assert property (@(posedge clk) disable iff (rst)
		product_done |=> !product_done)
	else begin
		fail_count++;
		$error("product_done held longer than one cycle");
	end

	a_add_shift: assert property (@(posedge clk) disable iff (rst)
		!(rs_add && rs_shift))
	else begin
		fail_count++;
		$error("rs_add and rs_shift high together");
	end

	a_reset_quiet: assert property (@(posedge clk)
		rst |=> !(rs_clear || md_load || mr_load || rs_add || rs_shift ||
			cnt_clear || cnt_step || product_done))
	else begin
		fail_count++;
		$error("strobe active in the cycle after reset");
	end

	// ==================================================================
	// APB
	// ==================================================================

	a_pready: assert property (@(posedge clk) pready)
	else begin
		fail_count++;
		$error("pready low");
	end

endmodule

bind taint_mult_top taint_mult_assert u_assert (
	.clk(clk), .rst(rst),
	.start(start), .product_done(product_done),
	.rs_clear(rs_clear), .md_load(md_load), .mr_load(mr_load),
	.rs_add(rs_add), .rs_shift(rs_shift),
	.cnt_clear(cnt_clear), .cnt_step(cnt_step),
	.mplier(mplier),
	.pready(pready)
);

/* dv/taint_mult_tb.sv */
// ======================================================================
// Testbench for the taint-tracking multiplier
// Clock, reset, APB tasks, five tests, result counts and watchdog
// ======================================================================

`timescale 1ns/1ps

module taint_mult_tb import taint_mult_pkg::*, apb_map_pkg::*;;

	localparam int CLK_PERIOD = 100;
	localparam int MAX_POLLS  = 20;
	// Multiplications over all tests, each about 40 cycles of APB traffic
	localparam int RUN_COUNT       = 27;
	localparam int RUN_CYCLES      = 40;
	localparam int WATCHDOG_CYCLES = 2 * RUN_COUNT * RUN_CYCLES + 100;

	logic                      clk;
	logic                      rst;
	logic                      psel;
	logic                      penable;
	logic                      pwrite;
	logic [APB_ADDR_WIDTH-1:0] paddr;
	logic [APB_DATA_WIDTH-1:0] pwdata;
	logic [APB_DATA_WIDTH-1:0] prdata;
	logic                      pready;
	logic                      pslverr;

	int    seed = 77;
	int    test_num = 0;
	string test_name;
	int    test_errors = 0;
	int    tests_passed = 0;
	int    tests_failed = 0;
	int    done_pulses = 0;

	taint_mult_top uut (
		.clk(clk), .rst(rst),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// product_done is stable over its whole cycle
	always @(negedge clk) begin
		if (!rst && uut.product_done) done_pulses++;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// ==================================================================
	// APB and check tasks
	// ==================================================================

	// Setup and access cycle, outputs sampled mid access cycle
	task automatic apb_access(input logic write, input logic [APB_ADDR_WIDTH-1:0] addr,
			input logic [APB_DATA_WIDTH-1:0] wdata,
			output logic [APB_DATA_WIDTH-1:0] rdata, output logic err);
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge clk);
		penable = 1'b1;
		#(CLK_PERIOD / 4);
		rdata = prdata;
		err   = pslverr;
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got == exp)
		else begin
			$display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic write_reg(input logic [APB_ADDR_WIDTH-1:0] addr,
			input logic [APB_DATA_WIDTH-1:0] data, input string name);
		logic [APB_DATA_WIDTH-1:0] unused_rdata;
		logic                      err;
		apb_access(1'b1, addr, data, unused_rdata, err);
		check_value({"pslverr on ", name}, 32'(err), 32'h0);
	endtask

	task automatic wait_done(output logic [APB_DATA_WIDTH-1:0] status);
		logic err;
		int   polls;
		polls  = 0;
		status = '0;
		while (!status[STATUS_DONE_BIT] && polls < MAX_POLLS) begin
			apb_access(1'b0, REG_STATUS, '0, status, err);
			polls++;
		end
		if (!status[STATUS_DONE_BIT]) begin
			$display("Timed out waiting for done after %0d status polls", polls);
			test_errors++;
		end
	endtask

	task automatic run_multiply(input logic [7:0] mc, input logic [7:0] mc_t,
			input logic [7:0] mr, input logic [7:0] mr_t, input logic st_t,
			output logic [15:0] prod, output logic [15:0] prod_t, output logic done_t);
		logic [APB_DATA_WIDTH-1:0] ctrl;
		logic [APB_DATA_WIDTH-1:0] status;
		logic [APB_DATA_WIDTH-1:0] data;
		logic                      err;
		ctrl = '0;
		ctrl[CTRL_START_BIT]   = 1'b1;
		ctrl[CTRL_START_T_BIT] = st_t;
		write_reg(REG_MCAND, 32'(mc), "MCAND");
		write_reg(REG_MCAND_T, 32'(mc_t), "MCAND_T");
		write_reg(REG_MPLIER, 32'(mr), "MPLIER");
		write_reg(REG_MPLIER_T, 32'(mr_t), "MPLIER_T");
		write_reg(REG_CTRL, ctrl, "CTRL");
		wait_done(status);
		done_t = status[STATUS_DONE_T_BIT];
		apb_access(1'b0, REG_PRODUCT, '0, data, err);
		prod = data[15:0];
		apb_access(1'b0, REG_PRODUCT_T, '0, data, err);
		prod_t = data[15:0];
	endtask

	task automatic begin_test(input string name);
		test_num++;
		test_name   = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		if (test_errors == 0) begin
			tests_passed++;
			$display("test %0d %s: ok", test_num, test_name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", test_num, test_name, test_errors);
		end
	endtask

	// ==================================================================
	// Stimulus
	// ==================================================================

	initial begin
		logic [7:0]                a;
		logic [7:0]                b;
		logic [15:0]               prod;
		logic [15:0]               prod_t;
		logic                      done_t;
		logic [APB_DATA_WIDTH-1:0] data;
		logic                      err;
		int                        pulses_before;

		rst     = 1'b1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		begin_test("untainted products");
		for (int i = 0; i < 20; i++) begin
			a = 8'($random(seed));
			b = 8'($random(seed));
			run_multiply(a, 8'h00, b, 8'h00, 1'b0, prod, prod_t, done_t);
			check_value("PRODUCT", 32'(prod), 32'(a) * 32'(b));
			check_value("PRODUCT_T", 32'(prod_t), 32'h0);
			check_value("STATUS.done_t", 32'(done_t), 32'h0);
		end
		end_test();

		// Tainted start taints the state from INIT on
		begin_test("start taint");
		run_multiply(8'h37, 8'h00, 8'hA5, 8'h00, 1'b1, prod, prod_t, done_t);
		check_value("PRODUCT", 32'(prod), 32'h37 * 32'hA5);
		check_value("PRODUCT_T", 32'(prod_t), 32'hFFFF);
		check_value("STATUS.done_t", 32'(done_t), 32'h1);
		end_test();

		begin_test("multiplier taint");
		run_multiply(8'hC3, 8'h00, 8'h6B, 8'h10, 1'b0, prod, prod_t, done_t);
		check_value("PRODUCT", 32'(prod), 32'hC3 * 32'h6B);
		check_value("PRODUCT_T", 32'(prod_t), 32'hFFFF);
		check_value("STATUS.done_t", 32'(done_t), 32'h1);
		run_multiply(8'h2D, 8'h00, 8'h81, 8'h80, 1'b0, prod, prod_t, done_t);
		check_value("PRODUCT", 32'(prod), 32'h2D * 32'h81);
		check_value("PRODUCT_T", 32'(prod_t), 32'hFFFF);
		// No adds, so a tainted multiplicand never reaches the result
		run_multiply(8'h9E, 8'hFF, 8'h00, 8'h00, 1'b0, prod, prod_t, done_t);
		check_value("PRODUCT", 32'(prod), 32'h0);
		check_value("PRODUCT_T", 32'(prod_t), 32'h0);
		check_value("STATUS.done_t", 32'(done_t), 32'h0);
		end_test();

		// Shortest and longest runs for the latency assertions
		begin_test("latency");
		run_multiply(8'hFF, 8'h00, 8'h00, 8'h00, 1'b0, prod, prod_t, done_t);
		check_value("PRODUCT", 32'(prod), 32'h0);
		run_multiply(8'hFF, 8'h00, 8'hFF, 8'h00, 1'b0, prod, prod_t, done_t);
		check_value("PRODUCT", 32'(prod), 32'hFE01);
		check_value("PRODUCT_T", 32'(prod_t), 32'h0);
		end_test();

		begin_test("apb rules");
		apb_access(1'b0, 8'h20, '0, data, err);
		check_value("pslverr on unmapped read", 32'(err), 32'h1);
		apb_access(1'b1, REG_STATUS, 32'h0, data, err);
		check_value("pslverr on STATUS write", 32'(err), 32'h1);
		apb_access(1'b1, REG_PRODUCT, 32'h0, data, err);
		check_value("pslverr on PRODUCT write", 32'(err), 32'h1);
		write_reg(REG_MCAND, 32'h5A, "MCAND");
		write_reg(REG_MCAND_T, 32'h0, "MCAND_T");
		write_reg(REG_MPLIER, 32'hFF, "MPLIER");
		write_reg(REG_MPLIER_T, 32'h0, "MPLIER_T");
		pulses_before = done_pulses;
		write_reg(REG_CTRL, 32'h1, "CTRL");
		apb_access(1'b1, REG_MCAND, 32'h11, data, err);
		check_value("pslverr on busy MCAND write", 32'(err), 32'h1);
		write_reg(REG_CTRL, 32'h1, "busy CTRL start");
		apb_access(1'b0, REG_MCAND, '0, data, err);
		check_value("MCAND", data, 32'h5A);
		wait_done(data);
		apb_access(1'b0, REG_PRODUCT, '0, data, err);
		check_value("PRODUCT", data, 32'h5A * 32'hFF);
		// Room for a second run, should the ignored start have slipped through
		repeat (20) @(negedge clk);
		check_value("product_done pulses", 32'(done_pulses - pulses_before), 32'h1);
		apb_access(1'b0, REG_STATUS, '0, data, err);
		check_value("STATUS.busy", 32'(data[STATUS_BUSY_BIT]), 32'h0);
		check_value("STATUS.done", 32'(data[STATUS_DONE_BIT]), 32'h1);
		end_test();

		$display("tests passed %0d, failed %0d, assertion failures %0d",
			tests_passed, tests_failed, uut.u_assert.fail_count);
		if (tests_failed == 0 && uut.u_assert.fail_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* compile.f */
rtl/taint_mult_pkg.sv
rtl/apb_map_pkg.sv
rtl/bit_counter.sv
rtl/mult_ctrl.sv
rtl/mult_datapath.sv
rtl/apb_mult_regs.sv
rtl/taint_mult_top.sv
dv/taint_mult_assert.sv
dv/taint_mult_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = taint_mult_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
RUN_FLAGS = +verilator+error+limit+1000
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST RESULT: PASS$$"

clean:
	rm -rf $(OBJ_DIR)
